/* all.f */
arp_pkg.sv
arp_fifo.sv
arp_addr_classify.sv
arp_cache.sv
arp_resolver.sv
arp_frame_rx.sv
arp_tx_arb.sv
arp_top.sv
arp_sva.sv
tb_arp.sv

/* run.sh */
#!/bin/sh
# build and run tb_arp with Verilator, exit status follows the testbench result
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_arp -f all.f -o tb_arp \
    > build.log 2>&1 \
    && ./obj_dir/tb_arp > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log || exit 1
exit 0

/* tb_arp.sv */
////////////////////////////////////////
// directed testbench for arp_top
// expected values assume the parameters set below
////////////////////////////////////////

`timescale 1ns/1ps

module tb_arp;
    localparam int cache_addr_width = 4;
    localparam int retry_count = 3;
    localparam int tick_cycles = 4;
    localparam int retry_interval = 5;
    localparam int request_timeout = 10;
    localparam int reset_cycles = 10;
    localparam int stall_cycles = 8;
    // longest lookup is a full retry run that ends in an error
    localparam int lookup_worst = tick_cycles
        * ((retry_count - 1) * retry_interval + request_timeout + retry_count + 2) + 20;
    localparam int timeout_cycles = reset_cycles + 8 * lookup_worst + 2 * stall_cycles + 100;

    localparam arp_pkg::ip_t own_ip = 32'h0a00_0002;
    localparam arp_pkg::ip_t gw_ip = 32'h0a00_0001;
    localparam arp_pkg::ip_t net_mask = 32'hffff_ff00;
    localparam arp_pkg::ip_t peer7 = 32'h0a00_0007;
    localparam arp_pkg::ip_t peer9 = 32'h0a00_0009;
    localparam arp_pkg::ip_t remote_ip = 32'hc0a8_0105;

    logic clk;
    logic rst;
    logic lookup_valid;
    logic lookup_ready;
    arp_pkg::ip_t lookup_ip;
    logic resp_valid;
    logic resp_ready;
    arp_pkg::arp_resp_t resp;
    logic frame_in_valid;
    logic frame_in_ready;
    arp_pkg::arp_frame_t frame_in;
    logic frame_out_valid;
    logic frame_out_ready;
    arp_pkg::arp_frame_t frame_out;
    arp_pkg::mac_t local_mac;
    arp_pkg::ip_t local_ip;
    arp_pkg::ip_t gateway_ip;
    arp_pkg::ip_t subnet_mask;
    logic clear_cache;

    arp_pkg::arp_frame_t frame_q[$];
    arp_pkg::arp_resp_t resp_q[$];
    logic [31:0] lfsr_state;
    int error_count;
    int check_count;
    int cycle_count;

    arp_top #(
        .cache_addr_width(cache_addr_width),
        .retry_count(retry_count),
        .tick_cycles(tick_cycles),
        .retry_interval(retry_interval),
        .request_timeout(request_timeout)
    ) dut (
        .clk(clk), .rst(rst),
        .lookup_valid(lookup_valid), .lookup_ready(lookup_ready), .lookup_ip(lookup_ip),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp(resp),
        .frame_in_valid(frame_in_valid), .frame_in_ready(frame_in_ready),
        .frame_in(frame_in),
        .frame_out_valid(frame_out_valid), .frame_out_ready(frame_out_ready),
        .frame_out(frame_out),
        .local_mac(local_mac), .local_ip(local_ip),
        .gateway_ip(gateway_ip), .subnet_mask(subnet_mask),
        .clear_cache(clear_cache)
    );

    always #20 clk = ~clk;

    // collect every accepted frame and response
    always @(posedge clk) begin
        if (!rst && frame_out_valid && frame_out_ready) begin
            frame_q.push_back(frame_out);
        end
        if (!rst && resp_valid && resp_ready) begin
            resp_q.push_back(resp);
        end
    end

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic random_mac(output arp_pkg::mac_t m);
        for (int i = 0; i < 48; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            m[i] = lfsr_state[0];
        end
    endtask

    function automatic arp_pkg::arp_frame_t make_frame(
        input arp_pkg::oper_t oper, input arp_pkg::mac_t sha, input arp_pkg::ip_t spa,
        input arp_pkg::mac_t tha, input arp_pkg::ip_t tpa
    );
        arp_pkg::arp_frame_t f;
        f.oper = oper;
        f.sha = sha;
        f.spa = spa;
        f.tha = tha;
        f.tpa = tpa;
        return f;
    endfunction

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        check_count++;
        assert (got === exp) else begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    task automatic check_true(input logic cond, input string msg);
        check_count++;
        assert (cond) else begin
            $display("%s", msg);
            error_count++;
        end
    endtask

    task automatic check_frame(input arp_pkg::arp_frame_t got,
                               input arp_pkg::arp_frame_t exp);
        check_field("frame_out.oper", 64'(got.oper), 64'(exp.oper));
        check_field("frame_out.sha", 64'(got.sha), 64'(exp.sha));
        check_field("frame_out.spa", 64'(got.spa), 64'(exp.spa));
        check_field("frame_out.tha", 64'(got.tha), 64'(exp.tha));
        check_field("frame_out.tpa", 64'(got.tpa), 64'(exp.tpa));
    endtask

    task automatic check_resp(input arp_pkg::arp_resp_t got, input logic exp_error,
                              input arp_pkg::mac_t exp_mac);
        check_field("resp.error", 64'(got.error), 64'(exp_error));
        check_field("resp.mac", 64'(got.mac), 64'(exp_mac));
    endtask

    task automatic do_lookup(input arp_pkg::ip_t ip);
        @(negedge clk);
        lookup_ip = ip;
        lookup_valid = 1'b1;
        while (!lookup_ready) begin
            @(negedge clk);
        end
        // handshake happens on the posedge before this
        @(negedge clk);
        lookup_valid = 1'b0;
    endtask

    task automatic send_frame(input arp_pkg::arp_frame_t f);
        @(negedge clk);
        frame_in = f;
        frame_in_valid = 1'b1;
        while (!frame_in_ready) begin
            @(negedge clk);
        end
        @(negedge clk);
        frame_in_valid = 1'b0;
    endtask

    task automatic wait_resp(output arp_pkg::arp_resp_t r);
        while (resp_q.size() == 0) begin
            @(negedge clk);
        end
        r = resp_q.pop_front();
    endtask

    task automatic wait_frame(output arp_pkg::arp_frame_t f);
        while (frame_q.size() == 0) begin
            @(negedge clk);
        end
        f = frame_q.pop_front();
    endtask

    task automatic test_broadcast();
        arp_pkg::arp_resp_t r;
        do_lookup(32'hffff_ffff);
        wait_resp(r);
        check_resp(r, 1'b0, arp_pkg::MAC_BROADCAST);
        do_lookup(32'h0a00_00ff);
        wait_resp(r);
        check_resp(r, 1'b0, arp_pkg::MAC_BROADCAST);
        check_true(frame_q.size() == 0, "broadcast lookup sent a frame on frame_out");
    endtask

    task automatic test_reply_learn();
        arp_pkg::mac_t peer_mac;
        arp_pkg::arp_frame_t f;
        arp_pkg::arp_resp_t r;
        random_mac(peer_mac);
        send_frame(make_frame(arp_pkg::OPER_REQUEST, peer_mac, peer7, 48'h0, own_ip));
        wait_frame(f);
        check_frame(f, make_frame(arp_pkg::OPER_REPLY, local_mac, own_ip, peer_mac, peer7));
        // sender was learned from the request
        do_lookup(peer7);
        wait_resp(r);
        check_resp(r, 1'b0, peer_mac);
        check_true(frame_q.size() == 0, "cache hit still sent a frame on frame_out");
    endtask

    task automatic test_miss_resolved();
        arp_pkg::mac_t peer_mac;
        arp_pkg::arp_frame_t f;
        arp_pkg::arp_resp_t r;
        random_mac(peer_mac);
        do_lookup(peer9);
        wait_frame(f);
        check_frame(f, make_frame(arp_pkg::OPER_REQUEST, local_mac, own_ip, 48'h0, peer9));
        send_frame(make_frame(arp_pkg::OPER_REPLY, peer_mac, peer9, local_mac, own_ip));
        wait_resp(r);
        check_resp(r, 1'b0, peer_mac);
        check_true(frame_q.size() == 0, "extra request sent after the reply was learned");
    endtask

    task automatic test_gateway();
        arp_pkg::arp_frame_t f;
        arp_pkg::arp_resp_t r;
        int n;
        do_lookup(remote_ip);
        wait_resp(r);
        check_field("resp.error", 64'(r.error), 64'(1'b1));
        n = frame_q.size();
        check_true(n == retry_count,
            $sformatf("expected %0d request frames before the error, saw %0d", retry_count, n));
        while (frame_q.size() > 0) begin
            f = frame_q.pop_front();
            check_frame(f, make_frame(arp_pkg::OPER_REQUEST, local_mac, own_ip, 48'h0, gw_ip));
        end
    endtask

    task automatic test_clear_stall();
        arp_pkg::mac_t peer_mac;
        arp_pkg::arp_frame_t held;
        arp_pkg::arp_frame_t exp_req;
        arp_pkg::arp_frame_t f;
        arp_pkg::arp_resp_t r;
        exp_req = make_frame(arp_pkg::OPER_REQUEST, local_mac, own_ip, 48'h0, peer7);
        @(negedge clk);
        clear_cache = 1'b1;
        @(negedge clk);
        clear_cache = 1'b0;
        frame_out_ready = 1'b0;
        do_lookup(peer7);
        while (!frame_out_valid) begin
            @(negedge clk);
        end
        held = frame_out;
        check_frame(held, exp_req);
        repeat (stall_cycles) begin
            @(negedge clk);
            check_true(frame_out_valid, "frame_out_valid dropped while frame_out_ready was low");
            check_frame(frame_out, held);
        end
        @(negedge clk);
        frame_out_ready = 1'b1;
        wait_frame(f);
        check_frame(f, held);
        // finish the lookup with a reply from the peer, response held back
        resp_ready = 1'b0;
        random_mac(peer_mac);
        send_frame(make_frame(arp_pkg::OPER_REPLY, peer_mac, peer7, local_mac, own_ip));
        while (!resp_valid) begin
            @(negedge clk);
        end
        repeat (stall_cycles) begin
            @(negedge clk);
            check_true(resp_valid, "resp_valid dropped while resp_ready was low");
            check_true(!lookup_ready, "lookup_ready high while a response was pending");
            check_resp(resp, 1'b0, peer_mac);
        end
        resp_ready = 1'b1;
        wait_resp(r);
        check_resp(r, 1'b0, peer_mac);
        repeat (4) @(negedge clk);
        while (frame_q.size() > 0) begin
            f = frame_q.pop_front();
            check_frame(f, exp_req);
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles with no DUT response, checks %0d, errors %0d",
            cycle_count, check_count, error_count);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        lookup_valid = 1'b0;
        lookup_ip = '0;
        resp_ready = 1'b1;
        frame_in_valid = 1'b0;
        frame_in = '0;
        frame_out_ready = 1'b1;
        local_ip = own_ip;
        gateway_ip = gw_ip;
        subnet_mask = net_mask;
        clear_cache = 1'b0;
        error_count = 0;
        check_count = 0;
        lfsr_state = 32'h50f;
        random_mac(local_mac);
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        test_broadcast();
        test_reply_learn();
        test_miss_resolved();
        test_gateway();
        test_clear_stall();

        repeat (4) @(negedge clk);
        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* arp_sva.sv */
////////////////////////////////////////
// handshake checks bound into arp_top
////////////////////////////////////////

`timescale 1ns/1ps

module arp_sva (
    input logic                clk,
    input logic                rst,
    input logic                frame_out_valid,
    input logic                frame_out_ready,
    input arp_pkg::arp_frame_t frame_out,
    input logic                resp_valid,
    input logic                resp_ready,
    input arp_pkg::arp_resp_t  resp,
    input logic                lookup_ready
);

    // stalled frame must stay put
    frame_out_hold: assert property (@(posedge clk) disable iff (rst)
        frame_out_valid && !frame_out_ready |=> frame_out_valid && $stable(frame_out))
        else $error("frame_out changed while stalled");

    resp_hold: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else $error("resp changed while stalled");

    // one lookup in flight at a time
    no_lookup_during_resp: assert property (@(posedge clk) disable iff (rst)
        resp_valid |-> !lookup_ready)
        else $error("lookup_ready high while a response is pending");

endmodule

bind arp_top arp_sva sva (
    .clk(clk),
    .rst(rst),
    .frame_out_valid(frame_out_valid),
    .frame_out_ready(frame_out_ready),
    .frame_out(frame_out),
    .resp_valid(resp_valid),
    .resp_ready(resp_ready),
    .resp(resp),
    .lookup_ready(lookup_ready)
);

/* arp_top.sv */
////////////////////////////////////////
// ARP resolver top, parsed frames only
// configuration inputs are assumed static
////////////////////////////////////////

`timescale 1ns/1ps

module arp_top #(
    parameter int cache_addr_width = 4,
    parameter int retry_count = 3,
    parameter int tick_cycles = 4,
    parameter int retry_interval = 5,
    parameter int request_timeout = 10
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                lookup_valid,
    output logic                lookup_ready,
    input  arp_pkg::ip_t        lookup_ip,
    output logic                resp_valid,
    input  logic                resp_ready,
    output arp_pkg::arp_resp_t  resp,
    input  logic                frame_in_valid,
    output logic                frame_in_ready,
    input  arp_pkg::arp_frame_t frame_in,
    output logic                frame_out_valid,
    input  logic                frame_out_ready,
    output arp_pkg::arp_frame_t frame_out,
    input  arp_pkg::mac_t       local_mac,
    input  arp_pkg::ip_t        local_ip,
    input  arp_pkg::ip_t        gateway_ip,
    input  arp_pkg::ip_t        subnet_mask,
    input  logic                clear_cache
);
    logic lk_valid;
    logic lk_ready;
    arp_pkg::lookup_t lk;
    logic q_valid;
    arp_pkg::ip_t q_ip;
    logic r_valid;
    logic r_hit;
    arp_pkg::mac_t r_mac;
    logic wr_valid;
    arp_pkg::cache_wr_t wr;
    logic req_valid;
    logic req_ready;
    arp_pkg::arp_frame_t req;
    logic rx_rep_valid;
    logic rx_rep_ready;
    arp_pkg::arp_frame_t rx_rep;
    logic q_rep_valid;
    logic q_rep_ready;
    arp_pkg::arp_frame_t q_rep;

    arp_addr_classify classify (
        .clk(clk), .rst(rst),
        .lookup_valid(lookup_valid), .lookup_ready(lookup_ready), .lookup_ip(lookup_ip),
        .gateway_ip(gateway_ip), .subnet_mask(subnet_mask),
        .lk_valid(lk_valid), .lk_ready(lk_ready), .lk(lk)
    );

    arp_resolver #(
        .retry_count(retry_count),
        .tick_cycles(tick_cycles),
        .retry_interval(retry_interval),
        .request_timeout(request_timeout)
    ) resolver (
        .clk(clk), .rst(rst),
        .lk_valid(lk_valid), .lk_ready(lk_ready), .lk(lk),
        .q_valid(q_valid), .q_ip(q_ip),
        .r_valid(r_valid), .r_hit(r_hit), .r_mac(r_mac),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .local_mac(local_mac), .local_ip(local_ip),
        .resp_valid(resp_valid), .resp_ready(resp_ready), .resp(resp)
    );

    arp_cache #(
        .cache_addr_width(cache_addr_width)
    ) cache (
        .clk(clk), .rst(rst),
        .q_valid(q_valid), .q_ip(q_ip),
        .r_valid(r_valid), .r_hit(r_hit), .r_mac(r_mac),
        .wr_valid(wr_valid), .wr(wr), .clear_cache(clear_cache)
    );

    arp_frame_rx frame_rx (
        .clk(clk), .rst(rst),
        .frame_in_valid(frame_in_valid), .frame_in_ready(frame_in_ready),
        .frame_in(frame_in),
        .local_mac(local_mac), .local_ip(local_ip),
        .wr_valid(wr_valid), .wr(wr),
        .rep_valid(rx_rep_valid), .rep_ready(rx_rep_ready), .rep(rx_rep)
    );

    // reply queue between frame rx and the arbiter
    arp_fifo #(
        .depth(2),
        .payload_t(arp_pkg::arp_frame_t)
    ) rep_fifo (
        .clk(clk), .rst(rst),
        .in_valid(rx_rep_valid), .in_ready(rx_rep_ready), .in_data(rx_rep),
        .out_valid(q_rep_valid), .out_ready(q_rep_ready), .out_data(q_rep)
    );

    arp_tx_arb tx_arb (
        .clk(clk), .rst(rst),
        .rep_valid(q_rep_valid), .rep_ready(q_rep_ready), .rep(q_rep),
        .req_valid(req_valid), .req_ready(req_ready), .req(req),
        .frame_out_valid(frame_out_valid), .frame_out_ready(frame_out_ready),
        .frame_out(frame_out)
    );

endmodule

/* arp_tx_arb.sv */
////////////////////////////////////////
// stage three, merges replies and requests
// round robin when both are waiting
////////////////////////////////////////

`timescale 1ns/1ps

module arp_tx_arb (
    input  logic                clk,
    input  logic                rst,
    input  logic                rep_valid,
    output logic                rep_ready,
    input  arp_pkg::arp_frame_t rep,
    input  logic                req_valid,
    output logic                req_ready,
    input  arp_pkg::arp_frame_t req,
    output logic                frame_out_valid,
    input  logic                frame_out_ready,
    output arp_pkg::arp_frame_t frame_out
);
    logic last_rep;
    logic grant_rep;
    logic out_in_ready;
    arp_pkg::arp_frame_t out_in_data;

    // a reply wins unless it was also served last
    assign grant_rep = rep_valid && (!req_valid || !last_rep);
    assign rep_ready = out_in_ready && grant_rep;
    assign req_ready = out_in_ready && !grant_rep;
    assign out_in_data = grant_rep ? rep : req;

    always_ff @(posedge clk) begin
        if (rst) begin
            last_rep <= 1'b0;
        end else if (out_in_ready && (rep_valid || req_valid)) begin
            last_rep <= grant_rep;
        end
    end

    arp_fifo #(
        .depth(2),
        .payload_t(arp_pkg::arp_frame_t)
    ) out_reg (
        .clk(clk),
        .rst(rst),
        .in_valid(rep_valid || req_valid),
        .in_ready(out_in_ready),
        .in_data(out_in_data),
        .out_valid(frame_out_valid),
        .out_ready(frame_out_ready),
        .out_data(frame_out)
    );

endmodule

/* arp_frame_rx.sv */
////////////////////////////////////////
// incoming ARP frames, learns senders
// replies go out combinationally to the reply queue
////////////////////////////////////////

`timescale 1ns/1ps

module arp_frame_rx (
    input  logic                clk,
    input  logic                rst,
    input  logic                frame_in_valid,
    output logic                frame_in_ready,
    input  arp_pkg::arp_frame_t frame_in,
    input  arp_pkg::mac_t       local_mac,
    input  arp_pkg::ip_t        local_ip,
    output logic                wr_valid,
    output arp_pkg::cache_wr_t  wr,
    output logic                rep_valid,
    input  logic                rep_ready,
    output arp_pkg::arp_frame_t rep
);
    logic accept;
    logic is_request;
    logic is_arp;

    assign frame_in_ready = rep_ready;
    assign accept = frame_in_valid && frame_in_ready;
    assign is_request = frame_in.oper == arp_pkg::OPER_REQUEST;
    assign is_arp = is_request || (frame_in.oper == arp_pkg::OPER_REPLY);

    // only requests aimed at us get an answer
    assign rep_valid = frame_in_valid && is_request && (frame_in.tpa == local_ip);

    always_comb begin
        rep.oper = arp_pkg::OPER_REPLY;
        rep.sha = local_mac;
        rep.spa = local_ip;
        rep.tha = frame_in.sha;
        rep.tpa = frame_in.spa;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_valid <= 1'b0;
        end else begin
            wr_valid <= accept && is_arp;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            wr.ip <= frame_in.spa;
            wr.mac <= frame_in.sha;
        end
    end

endmodule

/* arp_resolver.sv */
////////////////////////////////////////
// lookup stage two, one lookup at a time
// timers count ticks of tick_cycles clocks
// retry timer pauses while a request waits
////////////////////////////////////////

`timescale 1ns/1ps

module arp_resolver #(
    parameter int retry_count = 3,
    parameter int tick_cycles = 4,
    parameter int retry_interval = 5,
    parameter int request_timeout = 10
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                lk_valid,
    output logic                lk_ready,
    input  arp_pkg::lookup_t    lk,
    output logic                q_valid,
    output arp_pkg::ip_t        q_ip,
    input  logic                r_valid,
    input  logic                r_hit,
    input  arp_pkg::mac_t       r_mac,
    output logic                req_valid,
    input  logic                req_ready,
    output arp_pkg::arp_frame_t req,
    input  arp_pkg::mac_t       local_mac,
    input  arp_pkg::ip_t        local_ip,
    output logic                resp_valid,
    input  logic                resp_ready,
    output arp_pkg::arp_resp_t  resp
);
    localparam int presc_width = $clog2(tick_cycles + 1);
    localparam int timer_width = $clog2(retry_interval + request_timeout + 1);
    localparam int sent_width = $clog2(retry_count + 1);

    typedef enum logic [2:0] {
        st_idle,
        st_query,
        st_send,
        st_wait,
        st_resp
    } state_t;

    state_t state;
    arp_pkg::ip_t target;
    logic [presc_width-1:0] presc;
    logic tick;
    logic [timer_width-1:0] timer;
    logic [sent_width-1:0] sent;

    assign q_ip = target;
    assign req_valid = state == st_send;
    assign resp_valid = state == st_resp;
    assign tick = presc == '0;

    always_comb begin
        req.oper = arp_pkg::OPER_REQUEST;
        req.sha = local_mac;
        req.spa = local_ip;
        req.tha = '0;
        req.tpa = target;
    end

    // free running tick prescaler
    always_ff @(posedge clk) begin
        if (rst) begin
            presc <= '0;
        end else begin
            presc <= tick ? presc_width'(tick_cycles - 1) : presc - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            lk_ready <= 1'b0;
            q_valid <= 1'b0;
            sent <= '0;
        end else begin
            q_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (lk_valid && lk_ready) begin
                        lk_ready <= 1'b0;
                        target <= lk.ip;
                        sent <= '0;
                        if (lk.bcast) begin
                            resp.error <= 1'b0;
                            resp.mac <= arp_pkg::MAC_BROADCAST;
                            state <= st_resp;
                        end else begin
                            q_valid <= 1'b1;
                            state <= st_query;
                        end
                    end else begin
                        lk_ready <= 1'b1;
                    end
                end
                st_query: begin
                    if (r_valid) begin
                        if (r_hit) begin
                            resp.error <= 1'b0;
                            resp.mac <= r_mac;
                            state <= st_resp;
                        end else if (sent == '0 || timer == '0) begin
                            // first miss, or the current interval ran out
                            if (sent == sent_width'(retry_count)) begin
                                resp.error <= 1'b1;
                                resp.mac <= '0;
                                state <= st_resp;
                            end else begin
                                state <= st_send;
                            end
                        end else begin
                            state <= st_wait;
                        end
                    end
                end
                st_send: begin
                    if (req_ready) begin
                        sent <= sent + 1'b1;
                        // last request waits for the final timeout
                        timer <= (sent == sent_width'(retry_count - 1))
                            ? timer_width'(request_timeout)
                            : timer_width'(retry_interval);
                        state <= st_wait;
                    end
                end
                st_wait: begin
                    // poll the cache once per tick
                    if (tick) begin
                        timer <= timer - 1'b1;
                        q_valid <= 1'b1;
                        state <= st_query;
                    end
                end
                st_resp: begin
                    if (resp_ready) begin
                        lk_ready <= 1'b1;
                        state <= st_idle;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

endmodule

/* arp_cache.sv */
////////////////////////////////////////
// direct-mapped IP to MAC cache
// one cycle query latency, no back-pressure
// a write shows up in queries from the next cycle
////////////////////////////////////////

`timescale 1ns/1ps

module arp_cache #(
    parameter int cache_addr_width = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               q_valid,
    input  arp_pkg::ip_t       q_ip,
    output logic               r_valid,
    output logic               r_hit,
    output arp_pkg::mac_t      r_mac,
    input  logic               wr_valid,
    input  arp_pkg::cache_wr_t wr,
    input  logic               clear_cache
);
    localparam int entries = 1 << cache_addr_width;

    logic [entries-1:0] entry_valid;
    arp_pkg::ip_t tag_mem [entries];
    arp_pkg::mac_t mac_mem [entries];
    logic [cache_addr_width-1:0] q_idx;
    logic [cache_addr_width-1:0] wr_idx;

    // index is the low bits of the address
    assign q_idx = q_ip[cache_addr_width-1:0];
    assign wr_idx = wr.ip[cache_addr_width-1:0];

    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
            r_valid <= 1'b0;
        end else begin
            r_valid <= q_valid;
            if (clear_cache) begin
                entry_valid <= '0;
            end else if (wr_valid) begin
                entry_valid[wr_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        // newer write simply replaces the entry
        if (wr_valid) begin
            tag_mem[wr_idx] <= wr.ip;
            mac_mem[wr_idx] <= wr.mac;
        end
        r_hit <= entry_valid[q_idx] && (tag_mem[q_idx] == q_ip);
        r_mac <= mac_mem[q_idx];
    end

endmodule

/* arp_addr_classify.sv */
////////////////////////////////////////
// lookup stage one, one cycle latency
// subnet config must be stable during a lookup
////////////////////////////////////////

`timescale 1ns/1ps

module arp_addr_classify (
    input  logic             clk,
    input  logic             rst,
    input  logic             lookup_valid,
    output logic             lookup_ready,
    input  arp_pkg::ip_t     lookup_ip,
    input  arp_pkg::ip_t     gateway_ip,
    input  arp_pkg::ip_t     subnet_mask,
    output logic             lk_valid,
    input  logic             lk_ready,
    output arp_pkg::lookup_t lk
);
    logic on_subnet;
    logic host_all_ones;
    logic accept;

    // lk_ready already stays low while the resolver holds a lookup
    assign lookup_ready = lk_ready && !lk_valid;
    assign accept = lookup_valid && lookup_ready;

    // same network part as the gateway
    assign on_subnet = ((lookup_ip ^ gateway_ip) & subnet_mask) == '0;
    assign host_all_ones = (lookup_ip | subnet_mask) == arp_pkg::IP_BROADCAST;

    always_ff @(posedge clk) begin
        if (rst) begin
            lk_valid <= 1'b0;
        end else if (accept) begin
            lk_valid <= 1'b1;
        end else if (lk_ready) begin
            lk_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            lk.bcast <= (lookup_ip == arp_pkg::IP_BROADCAST) || (on_subnet && host_all_ones);
            // off-subnet hosts are reached through the gateway
            lk.ip <= on_subnet ? lookup_ip : gateway_ip;
        end
    end

endmodule

/* arp_fifo.sv */
////////////////////////////////////////
// valid/ready queue, depth entries
// out_data comes straight from storage
////////////////////////////////////////

`timescale 1ns/1ps

module arp_fifo #(
    parameter int depth = 2,
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);
    localparam int ptr_width = (depth > 1) ? $clog2(depth) : 1;
    localparam int cnt_width = $clog2(depth + 1);

    payload_t mem [depth];
    logic [ptr_width-1:0] wr_ptr;
    logic [ptr_width-1:0] rd_ptr;
    logic [cnt_width-1:0] count;
    logic push;
    logic pop;

    assign in_ready = count != cnt_width'(depth);
    assign out_valid = count != '0;
    assign out_data = mem[rd_ptr];
    assign push = in_valid && in_ready;
    assign pop = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ptr_width'(depth - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ptr_width'(depth - 1)) ? '0 : rd_ptr + 1'b1;
            end
            // simultaneous push and pop leaves the count alone
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_data;
        end
    end

endmodule

/* arp_pkg.sv */
////////////////////////////////////////
// shared ARP types and constants
// frames are already parsed, no Ethernet header fields
////////////////////////////////////////

package arp_pkg;

    typedef logic [47:0] mac_t;
    typedef logic [31:0] ip_t;
    typedef logic [15:0] oper_t;

    localparam oper_t OPER_REQUEST = 16'h0001;
    localparam oper_t OPER_REPLY = 16'h0002;

    localparam mac_t MAC_BROADCAST = 48'hffff_ffff_ffff;
    localparam ip_t IP_BROADCAST = 32'hffff_ffff;

    // ARP payload without htype, ptype, hlen and plen
    typedef struct packed {
        oper_t oper;
        mac_t  sha;
        ip_t   spa;
        mac_t  tha;
        ip_t   tpa;
    } arp_frame_t;

    // classified lookup, ip is already the next-hop address
    typedef struct packed {
        ip_t  ip;
        logic bcast;
    } lookup_t;

    typedef struct packed {
        ip_t  ip;
        mac_t mac;
    } cache_wr_t;

    typedef struct packed {
        logic error;
        mac_t mac;
    } arp_resp_t;

endpackage
